// ==== design/snn_cfg.svh ====
// SNN core configuration macros
// Array sizes, datapath widths and the configuration address map
`ifndef SNN_CFG_SVH
`define SNN_CFG_SVH

// ------------------------------------------------------------
// Array sizes
`define SNN_NUM_AXONS         8
`define SNN_NUM_NEURONS       8
`define SNN_QUEUE_DEPTH       8
`define SNN_AXON_ID_W         $clog2(`SNN_NUM_AXONS)
`define SNN_NEURON_ID_W       $clog2(`SNN_NUM_NEURONS)

// Datapath widths
`define SNN_WEIGHT_W          8
`define SNN_POT_W             16
`define SNN_CNT_W             16
`define SNN_CFG_ADDR_W        8
`define SNN_CFG_DATA_W        16

// ------------------------------------------------------------
// Configuration address map
`define SNN_ADDR_CTRL         8'h00
`define SNN_ADDR_THRESH       8'h04
`define SNN_ADDR_LEAK         8'h08
`define SNN_ADDR_IRQ_THRESH   8'h0C
// Weight region, addr[5:3] axon and addr[2:0] neuron
`define SNN_ADDR_WEIGHT_BASE  8'h80
`define SNN_ADDR_WEIGHT_MASK  8'hC0

// Control register bits
`define SNN_CTRL_EN_BIT       0
`define SNN_CTRL_IRQ_EN_BIT   1
`define SNN_CTRL_CLEAR_BIT    2

`endif

// ==== design/snn_pkg.sv ====
// SNN core types
// Id, weight, potential and count vectors plus the fan-out FSM states
package snn_pkg;

`include "snn_cfg.svh"

    // ------------------------------------------------------------
    // Identifiers
    typedef logic [`SNN_AXON_ID_W-1:0]   axon_id_t;
    typedef logic [`SNN_NEURON_ID_W-1:0] neuron_id_t;

    // Synaptic weight, two's complement
    typedef logic signed [`SNN_WEIGHT_W-1:0] weight_t;

    // Membrane potential, also used for threshold and leak
    typedef logic [`SNN_POT_W-1:0] potential_t;

    // Delivered spike count and interrupt threshold
    typedef logic [`SNN_CNT_W-1:0] spike_cnt_t;

    // ------------------------------------------------------------
    // Fan-out FSM
    typedef enum logic {
        fo_idle,
        // Walking neurons 0..N-1 for the latched axon
        fo_sweep
    } fanout_state_t;

endpackage

// ==== design/spike_event_if.sv ====
// Weighted synaptic event link
// Carries one neuron id and weight per valid/ready transfer
`timescale 1ns/10ps

interface spike_event_if import snn_pkg::*; ();

    // Event held stable until ready
    logic       valid;
    neuron_id_t neuron;
    weight_t    weight;

    // Neuron array can take an event
    logic       ready;

    // Fan-out side
    modport src (output valid, output neuron, output weight, input ready);

    // Neuron array side
    modport dst (input valid, input neuron, input weight, output ready);

endinterface

// ==== design/snn_cfg_regs.sv ====
// SNN configuration registers
// Decodes register writes into global settings and weight-table writes
`timescale 1ns/10ps
`include "snn_cfg.svh"

module snn_cfg_regs import snn_pkg::*; (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  logic                       cfg_we,
    input  logic [`SNN_CFG_ADDR_W-1:0] cfg_addr,
    input  logic [`SNN_CFG_DATA_W-1:0] cfg_wdata,
    output logic                       enable,
    output logic                       irq_enable,
    output logic                       clear,
    output potential_t                 threshold,
    output potential_t                 leak,
    output spike_cnt_t                 irq_threshold,
    output logic                       wt_we,
    output axon_id_t                   wt_axon,
    output neuron_id_t                 wt_neuron,
    output weight_t                    wt_data
);

    // Address decode
    logic ctrl_hit;
    logic wt_hit;

    assign ctrl_hit = cfg_we && (cfg_addr == `SNN_ADDR_CTRL);
    assign wt_hit   = cfg_we &&
                      ((cfg_addr & `SNN_ADDR_WEIGHT_MASK) == `SNN_ADDR_WEIGHT_BASE);

    // ------------------------------------------------------------
    // Global settings
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            enable        <= 1'b0;
            irq_enable    <= 1'b0;
            clear         <= 1'b0;
            threshold     <= '0;
            leak          <= '0;
            irq_threshold <= '0;
        end else begin
            // Clear only lives for the cycle after the write
            clear <= ctrl_hit && cfg_wdata[`SNN_CTRL_CLEAR_BIT];
            if (ctrl_hit) begin
                enable     <= cfg_wdata[`SNN_CTRL_EN_BIT];
                irq_enable <= cfg_wdata[`SNN_CTRL_IRQ_EN_BIT];
            end
            if (cfg_we && cfg_addr == `SNN_ADDR_THRESH)
                threshold <= cfg_wdata;
            if (cfg_we && cfg_addr == `SNN_ADDR_LEAK)
                leak <= cfg_wdata;
            if (cfg_we && cfg_addr == `SNN_ADDR_IRQ_THRESH)
                irq_threshold <= cfg_wdata;
        end
    end

    // ------------------------------------------------------------
    // Weight write command
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n)
            wt_we <= 1'b0;
        else
            wt_we <= wt_hit;
    end

    // Split fields, meaningful only with wt_we
    always_ff @(posedge sys_clk) begin
        wt_axon   <= cfg_addr[5:3];
        wt_neuron <= cfg_addr[2:0];
        wt_data   <= cfg_wdata[`SNN_WEIGHT_W-1:0];
    end

endmodule

// ==== design/synapse_fanout.sv ====
// Synapse fan-out
// Holds the weight table and expands each axon spike into one event per neuron
`timescale 1ns/10ps
`include "snn_cfg.svh"

module synapse_fanout import snn_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       enable,
    input  logic       in_valid,
    output logic       in_ready,
    input  axon_id_t   in_axon,
    input  logic       wt_we,
    input  axon_id_t   wt_axon,
    input  neuron_id_t wt_neuron,
    input  weight_t    wt_data,
    spike_event_if.src ev
);

    weight_t       weight_mem [`SNN_NUM_AXONS][`SNN_NUM_NEURONS];
    fanout_state_t state;
    axon_id_t      cur_axon;
    neuron_id_t    cur_neuron;
    logic          ev_xfer;
    logic          last_neuron;

    // ------------------------------------------------------------
    // Weight table, all zero out of reset
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            for (int a = 0; a < `SNN_NUM_AXONS; a++)
                for (int n = 0; n < `SNN_NUM_NEURONS; n++)
                    weight_mem[a][n] <= '0;
        end else if (wt_we) begin
            weight_mem[wt_axon][wt_neuron] <= wt_data;
        end
    end

    // Accept new axons only while idle and enabled
    assign in_ready    = (state == fo_idle) && enable;
    assign ev_xfer     = ev.valid && ev.ready;
    assign last_neuron = (cur_neuron == neuron_id_t'(`SNN_NUM_NEURONS - 1));

    // Event fields straight from the table row
    assign ev.valid  = (state == fo_sweep);
    assign ev.neuron = cur_neuron;
    assign ev.weight = weight_mem[cur_axon][cur_neuron];

    // ------------------------------------------------------------
    // Idle / sweep FSM
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state      <= fo_idle;
            cur_neuron <= '0;
        end else begin
            case (state)
                fo_idle: if (in_valid && in_ready) begin
                    state      <= fo_sweep;
                    cur_neuron <= '0;
                end
                fo_sweep: if (ev_xfer) begin
                    // Back to idle once the last neuron has gone out
                    if (last_neuron)
                        state <= fo_idle;
                    cur_neuron <= cur_neuron + 1'b1;
                end
                default: state <= fo_idle;
            endcase
        end
    end

    // Latched axon, payload only
    always_ff @(posedge sys_clk) begin
        if (in_valid && in_ready)
            cur_axon <= in_axon;
    end

endmodule

// ==== design/lif_neuron_array.sv ====
// Leaky integrate-and-fire neuron array
// Integrates weighted events, leaks on step and registers fired neuron ids
`timescale 1ns/10ps
`include "snn_cfg.svh"

module lif_neuron_array import snn_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       step,
    input  potential_t threshold,
    input  potential_t leak,
    spike_event_if.dst ev,
    output logic       fire_valid,
    input  logic       fire_ready,
    output neuron_id_t fire_neuron
);

    potential_t                 pot [`SNN_NUM_NEURONS];
    potential_t                 tgt_leaked;
    potential_t                 tgt_next;
    logic signed [`SNN_POT_W+1:0] tgt_sum;
    logic                       ev_xfer;
    logic                       fire_now;

    // Leak with floor at zero, bypassed without a step
    function automatic potential_t leak_of(potential_t p);
        if (!step)
            return p;
        return (p > leak) ? potential_t'(p - leak) : '0;
    endfunction

    // Stall events only while a fired id waits downstream
    assign ev.ready = !fire_valid || fire_ready;
    assign ev_xfer  = ev.valid && ev.ready;

    // ------------------------------------------------------------
    // Target neuron update, leak first then add
    always_comb begin
        tgt_leaked = leak_of(pot[ev.neuron]);
        tgt_sum    = $signed({2'b00, tgt_leaked}) + ev.weight;
        // Clamp at zero and at full scale
        if (tgt_sum < 0)
            tgt_next = '0;
        else if (tgt_sum > $signed({2'b00, {`SNN_POT_W{1'b1}}}))
            tgt_next = '1;
        else
            tgt_next = tgt_sum[`SNN_POT_W-1:0];
    end

    assign fire_now = ev_xfer && (tgt_next >= threshold);

    // Potentials
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < `SNN_NUM_NEURONS; i++)
                pot[i] <= '0;
        end else begin
            for (int i = 0; i < `SNN_NUM_NEURONS; i++) begin
                if (ev_xfer && ev.neuron == neuron_id_t'(i))
                    pot[i] <= fire_now ? '0 : tgt_next;
                else
                    pot[i] <= leak_of(pot[i]);
            end
        end
    end

    // ------------------------------------------------------------
    // One-entry fired spike register
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n)
            fire_valid <= 1'b0;
        else if (fire_now)
            fire_valid <= 1'b1;
        else if (fire_ready)
            fire_valid <= 1'b0;
    end

    always_ff @(posedge sys_clk) begin
        if (fire_now)
            fire_neuron <= ev.neuron;
    end

endmodule

// ==== design/spike_out_queue.sv ====
// Output spike queue
// FIFO of fired neuron ids with a delivered-spike counter and interrupt
`timescale 1ns/10ps
`include "snn_cfg.svh"

module spike_out_queue import snn_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       clear,
    input  logic       irq_enable,
    input  spike_cnt_t irq_threshold,
    input  logic       fire_valid,
    output logic       fire_ready,
    input  neuron_id_t fire_neuron,
    output logic       out_valid,
    input  logic       out_ready,
    output neuron_id_t out_neuron,
    output spike_cnt_t spike_count,
    output logic       interrupt
);

    localparam int PTR_W = $clog2(`SNN_QUEUE_DEPTH);

    neuron_id_t       mem [`SNN_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    // Full blocks the neuron array, empty hides the head
    assign fire_ready = (count != (PTR_W+1)'(`SNN_QUEUE_DEPTH));
    assign out_valid  = (count != '0);
    assign out_neuron = mem[rd_ptr];

    assign push = fire_valid && fire_ready;
    assign pop  = out_valid && out_ready;

    // ------------------------------------------------------------
    // Storage
    always_ff @(posedge sys_clk) begin
        if (push)
            mem[wr_ptr] <= fire_neuron;
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Delivered spike counter and level interrupt
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n || clear) begin
            spike_count <= '0;
            interrupt   <= 1'b0;
        end else begin
            if (pop)
                spike_count <= spike_count + 1'b1;
            interrupt <= irq_enable && (spike_count >= irq_threshold);
        end
    end

endmodule

// ==== design/snn_core_top.sv ====
// SNN core top level
// Configuration, synapse fan-out, LIF neuron array and output queue
`timescale 1ns/10ps
`include "snn_cfg.svh"

module snn_core_top (
    input  logic                          sys_clk,
    input  logic                          sys_rst_n,
    // Register writes
    input  logic                          cfg_we,
    input  logic [`SNN_CFG_ADDR_W-1:0]    cfg_addr,
    input  logic [`SNN_CFG_DATA_W-1:0]    cfg_wdata,
    // Time step pulse
    input  logic                          step,
    // Input axon spikes
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [`SNN_AXON_ID_W-1:0]     in_axon,
    // Output neuron spikes
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [`SNN_NEURON_ID_W-1:0]   out_neuron,
    // Status
    output logic [`SNN_CNT_W-1:0]         spike_count,
    output logic                          interrupt
);

    // ------------------------------------------------------------
    // Internal wiring
    logic                        enable;
    logic                        irq_enable;
    logic                        clear;
    logic [`SNN_POT_W-1:0]       threshold;
    logic [`SNN_POT_W-1:0]       leak;
    logic [`SNN_CNT_W-1:0]       irq_threshold;
    logic                        wt_we;
    logic [`SNN_AXON_ID_W-1:0]   wt_axon;
    logic [`SNN_NEURON_ID_W-1:0] wt_neuron;
    logic [`SNN_WEIGHT_W-1:0]    wt_data;
    logic                        fire_valid;
    logic                        fire_ready;
    logic [`SNN_NEURON_ID_W-1:0] fire_neuron;

    // Fan-out to neuron events
    spike_event_if ev ();

    snn_cfg_regs i_cfg_regs (
        .sys_clk, .sys_rst_n, .cfg_we, .cfg_addr, .cfg_wdata,
        .enable, .irq_enable, .clear, .threshold, .leak, .irq_threshold,
        .wt_we, .wt_axon, .wt_neuron, .wt_data
    );

    synapse_fanout i_fanout (
        .sys_clk, .sys_rst_n, .enable, .in_valid, .in_ready, .in_axon,
        .wt_we, .wt_axon, .wt_neuron, .wt_data, .ev(ev.src)
    );

    lif_neuron_array i_neurons (
        .sys_clk, .sys_rst_n, .step, .threshold, .leak, .ev(ev.dst),
        .fire_valid, .fire_ready, .fire_neuron
    );

    // Output side with counter and interrupt
    spike_out_queue i_queue (
        .sys_clk, .sys_rst_n, .clear, .irq_enable, .irq_threshold,
        .fire_valid, .fire_ready, .fire_neuron,
        .out_valid, .out_ready, .out_neuron, .spike_count, .interrupt
    );

endmodule

// ==== testbench/snn_core_props.sv ====
// SNN core handshake assertions
// Bound into the core top level to watch the event, queue and output links
`timescale 1ns/10ps
`include "snn_cfg.svh"

module snn_core_props (
    input logic                        sys_clk,
    input logic                        sys_rst_n,
    input logic                        cfg_we,
    input logic [`SNN_CFG_ADDR_W-1:0]  cfg_addr,
    input logic [`SNN_CFG_DATA_W-1:0]  cfg_wdata,
    input logic                        in_ready,
    input logic                        ev_valid,
    input logic                        ev_ready,
    input logic [`SNN_NEURON_ID_W-1:0] ev_neuron,
    input logic [`SNN_WEIGHT_W-1:0]    ev_weight,
    input logic                        fire_valid,
    input logic                        fire_ready,
    input logic                        out_valid,
    input logic                        out_ready,
    input logic [`SNN_NEURON_ID_W-1:0] out_neuron,
    input logic                        interrupt
);

    int   fail_count = 0;
    int   occ;
    logic en_shadow;

    // Shadow queue occupancy
    always @(posedge sys_clk) begin
        if (!sys_rst_n)
            occ <= 0;
        else
            occ <= occ + ((fire_valid && fire_ready) ? 1 : 0)
                       - ((out_valid && out_ready) ? 1 : 0);
    end

    // Core enable as last written through the control register
    always @(posedge sys_clk) begin
        if (!sys_rst_n)
            en_shadow <= 1'b0;
        else if (cfg_we && cfg_addr == `SNN_ADDR_CTRL)
            en_shadow <= cfg_wdata[`SNN_CTRL_EN_BIT];
    end

    // ------------------------------------------------------------
    a_ev_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        ev_valid && !ev_ready |=> ev_valid && $stable(ev_neuron) && $stable(ev_weight))
        else begin
            $error("event valid dropped or fields changed before ready");
            fail_count++;
        end

    a_out_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_neuron))
        else begin
            $error("out_valid dropped or out_neuron changed before out_ready");
            fail_count++;
        end

    a_in_ready_en: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !en_shadow |-> !in_ready)
        else begin
            $error("in_ready high while the core is disabled");
            fail_count++;
        end

    a_irq_reset: assert property (@(posedge sys_clk) !sys_rst_n |=> !interrupt)
        else begin
            $error("interrupt high right after reset");
            fail_count++;
        end

    // Push into a full queue would overwrite the head
    a_no_push_full: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        fire_valid && fire_ready |-> occ < `SNN_QUEUE_DEPTH)
        else begin
            $error("queue accepted a spike while full");
            fail_count++;
        end

endmodule

// ==== testbench/tb_snn_core.sv ====
// SNN core testbench
// Directed tests checked against a model of the LIF potentials
`timescale 1ns/10ps
`include "snn_cfg.svh"

module tb_snn_core;

    // About six times the roughly 1000 cycles the tests take
    localparam int MAX_CYCLES = 6000;
    localparam int NN         = `SNN_NUM_NEURONS;
    localparam logic [15:0] CTRL_EN    = 16'(1 << `SNN_CTRL_EN_BIT);
    localparam logic [15:0] CTRL_IRQ   = 16'(1 << `SNN_CTRL_IRQ_EN_BIT);
    localparam logic [15:0] CTRL_CLEAR = 16'(1 << `SNN_CTRL_CLEAR_BIT);

    logic                        sys_clk;
    logic                        sys_rst_n;
    logic                        cfg_we;
    logic [`SNN_CFG_ADDR_W-1:0]  cfg_addr;
    logic [`SNN_CFG_DATA_W-1:0]  cfg_wdata;
    logic                        step;
    logic                        in_valid;
    logic                        in_ready;
    logic [`SNN_AXON_ID_W-1:0]   in_axon;
    logic                        out_valid;
    logic                        out_ready;
    logic [`SNN_NEURON_ID_W-1:0] out_neuron;
    logic [`SNN_CNT_W-1:0]       spike_count;
    logic                        interrupt;

    // Reference model state
    int     pot_m [NN];
    int     wt_m [`SNN_NUM_AXONS][NN];
    int     thr_m;
    int     leak_m;
    int     exp_q [$];
    int     got_q [$];
    int     deliv_cnt;
    int     cycles = 0;
    int     checks;
    int     errors;
    int     test_errs;
    int     tests_failed;
    integer seed;

    snn_core_top i_dut (.*);

    bind snn_core_top snn_core_props i_props (
        .sys_clk, .sys_rst_n, .cfg_we, .cfg_addr, .cfg_wdata, .in_ready,
        .ev_valid(ev.valid), .ev_ready(ev.ready), .ev_neuron(ev.neuron),
        .ev_weight(ev.weight), .fire_valid, .fire_ready,
        .out_valid, .out_ready, .out_neuron, .interrupt
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    // Watchdog
    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Output monitor sampling each transfer before its rising edge
    always @(negedge sys_clk) begin
        if (sys_rst_n && out_valid && out_ready) begin
            got_q.push_back(int'(out_neuron));
            deliv_cnt++;
        end
    end

    // ------------------------------------------------------------
    // Model and error helpers
    function automatic void model_spike(int a);
        int p;
        for (int n = 0; n < NN; n++) begin
            p = pot_m[n] + wt_m[a][n];
            if (p < 0)
                p = 0;
            if (p > 65535)
                p = 65535;
            // Fire and reset
            if (p >= thr_m) begin
                exp_q.push_back(n);
                p = 0;
            end
            pot_m[n] = p;
        end
    endfunction

    function automatic void model_step();
        for (int n = 0; n < NN; n++)
            pot_m[n] = (pot_m[n] > leak_m) ? pot_m[n] - leak_m : 0;
    endfunction

    task automatic error_value(string sig, int exp_v, int got_v);
        $display("FAIL %s expected 0x%0h got 0x%0h", sig, exp_v, got_v);
        test_errs++;
    endtask

    task automatic error_text(string msg);
        $display("ERROR: %s", msg);
        test_errs++;
    endtask

    task automatic finish_test(string name);
        $display("%-14s %s with %0d errors", name, (test_errs == 0) ? "passed" : "failed",
                 test_errs);
        if (test_errs != 0)
            tests_failed++;
        errors += test_errs;
        test_errs = 0;
    endtask

    // ------------------------------------------------------------
    // Bus drivers
    task automatic cfg_write(logic [7:0] addr, logic [15:0] data);
        @(posedge sys_clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge sys_clk);
        cfg_we    <= 1'b0;
    endtask

    task automatic set_weight(int a, int n, int w);
        wt_m[a][n] = w;
        cfg_write(`SNN_ADDR_WEIGHT_BASE | 8'(a * NN + n), 16'(w & 255));
    endtask

    task automatic set_threshold(int t);
        thr_m = t;
        cfg_write(`SNN_ADDR_THRESH, 16'(t));
    endtask

    task automatic wait_accept(int a);
        do begin
            @(negedge sys_clk);
        end while (!in_ready);
        @(posedge sys_clk);
        in_valid <= 1'b0;
        model_spike(a);
    endtask

    task automatic send_spike(int a);
        @(posedge sys_clk);
        in_valid <= 1'b1;
        in_axon  <= 3'(a);
        wait_accept(a);
    endtask

    // Only between sweeps so the model sees leak before the next spike
    task automatic pulse_step();
        @(posedge sys_clk);
        step <= 1'b1;
        @(posedge sys_clk);
        step <= 1'b0;
        model_step();
    endtask

    task automatic wait_idle();
        do begin
            @(negedge sys_clk);
        end while (!in_ready);
    endtask

    task automatic check_outputs();
        int waited;
        int n;
        waited = 0;
        wait_idle();
        while (got_q.size() < exp_q.size() && waited < 200) begin
            @(negedge sys_clk);
            waited++;
        end
        // Room for a stray extra spike
        repeat (20) @(negedge sys_clk);
        checks++;
        if (got_q.size() != exp_q.size())
            error_text($sformatf("expected %0d output spikes but received %0d",
                                 exp_q.size(), got_q.size()));
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            if (got_q[i] != exp_q[i])
                error_value($sformatf("out_neuron[%0d]", i), exp_q[i], got_q[i]);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic check_status(logic irq_en, int irq_thr);
        logic irq_exp;
        repeat (2) @(negedge sys_clk);
        irq_exp = irq_en && (deliv_cnt >= irq_thr);
        checks++;
        if (spike_count !== 16'(deliv_cnt))
            error_value("spike_count", deliv_cnt, int'(spike_count));
        if (interrupt !== irq_exp)
            error_value("interrupt", int'(irq_exp), int'(interrupt));
    endtask

    // ------------------------------------------------------------
    // Directed tests
    task automatic test_enable_gate();
        set_threshold(100);
        for (int n = 0; n < NN; n++)
            set_weight(2, n, (n % 3 == 0) ? 120 : 40);
        // Spike held while the core is still disabled
        @(posedge sys_clk);
        in_valid <= 1'b1;
        in_axon  <= 3'd2;
        repeat (10) begin
            @(negedge sys_clk);
            checks++;
            if (in_ready)
                error_text("in_ready went high while the core was disabled");
        end
        cfg_write(`SNN_ADDR_CTRL, CTRL_EN);
        wait_accept(2);
        check_outputs();
        finish_test("enable_gate");
    endtask

    task automatic test_accumulate();
        for (int n = 0; n < NN; n++)
            set_weight(1, n, 20 + 5 * n);
        repeat (4) begin
            send_spike(1);
            check_outputs();
        end
        finish_test("accumulate");
    endtask

    task automatic test_leak();
        leak_m = 25;
        cfg_write(`SNN_ADDR_LEAK, 16'd25);
        for (int n = 0; n < NN; n++) begin
            set_weight(3, n, 45 + 4 * n);
            set_weight(4, n, -30 - 12 * n);
        end
        for (int r = 0; r < 6; r++) begin
            send_spike(3);
            check_outputs();
            pulse_step();
            // Negative weights drive some potentials to the zero floor
            if (r % 2 == 1) begin
                send_spike(4);
                check_outputs();
            end
            pulse_step();
        end
        finish_test("leak");
    endtask

    task automatic test_backpressure();
        int a;
        set_threshold(60);
        for (int n = 0; n < NN; n++) begin
            set_weight(5, n, ($random(seed) & 127) - 16);
            set_weight(6, n, ($random(seed) & 127) - 16);
        end
        @(posedge sys_clk);
        out_ready <= 1'b0;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    a = ($random(seed) & 1) ? 5 : 6;
                    send_spike(a);
                end
            end
            begin
                repeat (120) @(posedge sys_clk);
                @(negedge sys_clk);
                checks++;
                if (!out_valid)
                    error_text("queue held no spikes while out_ready was low");
                @(posedge sys_clk);
                out_ready <= 1'b1;
            end
        join
        check_outputs();
        finish_test("backpressure");
    endtask

    task automatic test_counter_irq();
        for (int n = 0; n < NN; n++)
            set_weight(7, n, (n < 2) ? 70 : 0);
        cfg_write(`SNN_ADDR_IRQ_THRESH, 16'd3);
        cfg_write(`SNN_ADDR_CTRL, CTRL_EN | CTRL_CLEAR);
        deliv_cnt = 0;
        check_status(1'b0, 3);
        // Count passes the threshold with the interrupt masked
        repeat (2) begin
            send_spike(7);
            check_outputs();
            check_status(1'b0, 3);
        end
        cfg_write(`SNN_ADDR_CTRL, CTRL_EN | CTRL_IRQ);
        check_status(1'b1, 3);
        cfg_write(`SNN_ADDR_CTRL, CTRL_EN | CTRL_IRQ | CTRL_CLEAR);
        deliv_cnt = 0;
        check_status(1'b1, 3);
        repeat (2) begin
            send_spike(7);
            check_outputs();
            check_status(1'b1, 3);
        end
        cfg_write(`SNN_ADDR_CTRL, CTRL_EN | CTRL_CLEAR);
        deliv_cnt = 0;
        check_status(1'b0, 3);
        finish_test("counter_irq");
    endtask

    // ------------------------------------------------------------
    initial begin
        seed      = 32'he368b2bc;
        sys_rst_n = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        step      = 1'b0;
        in_valid  = 1'b0;
        in_axon   = '0;
        out_ready = 1'b1;
        repeat (16) @(posedge sys_clk);
        sys_rst_n <= 1'b1;

        test_enable_gate();
        test_accumulate();
        test_leak();
        test_backpressure();
        test_counter_irq();

        if (i_dut.i_props.fail_count != 0) begin
            $display("ERROR: %0d handshake assertions failed", i_dut.i_props.fail_count);
            errors += i_dut.i_props.fail_count;
        end
        $display("Summary: 5 tests, %0d failed, %0d checks, %0d errors",
                 tests_failed, checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/snn_pkg.sv
design/spike_event_if.sv
design/snn_cfg_regs.sv
design/synapse_fanout.sv
design/lif_neuron_array.sv
design/spike_out_queue.sv
design/snn_core_top.sv
testbench/snn_core_props.sv
testbench/tb_snn_core.sv

// ==== Makefile ====
# Verilator build and run for the SNN core testbench

VERILATOR ?= verilator
TOP       ?= tb_snn_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) design/snn_cfg.svh

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the simulation prints the pass message
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
